//--- soc_bus_consts.svh
// ******************************
// Memory map of the peripheral bus
// Scratch memory depth
// Control register offsets and the
// UART timeout reset value
// ******************************
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// Scratch memory window, 4 bytes per word
`define MEM_BASE          32'h8000_0000
`define MEM_WORDS         64

// UART window, forwarded over APB
`define UART_BASE         32'hC000_0000
`define UART_SIZE         32'h0000_1000

// Control register window
`define CTRL_BASE         32'hD000_0000
`define CTRL_SIZE         32'h0000_1000
`define CTRL_EXIT_OFS     12'h000
`define CTRL_TIMEOUT_OFS  12'h004

`define UART_TIMEOUT_RST  8'd16

`endif

//--- soc_bus_pkg.sv
// ******************************
// Bus types of the peripheral bus
// Region and bus state enums
// ******************************
`include "soc_bus_consts.svh"

package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [11:0] offset_t;
  typedef logic [7:0]  timeout_t;

  // Word index into the scratch memory
  localparam int unsigned MEM_IDX_W = $clog2(`MEM_WORDS);
  typedef logic [MEM_IDX_W-1:0] mem_idx_t;

  typedef enum logic [1:0] {
    REGION_MEM,
    REGION_UART,
    REGION_CTRL,
    REGION_NONE
  } region_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOCAL,
    ST_UART_SETUP,
    ST_UART_ACCESS,
    ST_RESP
  } bus_state_e;

endpackage

//--- local_bus_if.sv
// ******************************
// Local access bus between the
// bus FSM and one local target
// ******************************
`timescale 1ns/1ps

interface local_bus_if;
  import soc_bus_pkg::*;

  logic    en;
  logic    write;
  offset_t offset;
  data_t   wdata;
  data_t   rdata;
  logic    err;

  // Bus FSM side
  modport master (output en, write, offset, wdata, input rdata, err);

  // Memory or register side
  modport target (input en, write, offset, wdata, output rdata, err);

endinterface

//--- soc_addr_decoder.sv
// ******************************
// Address decoder, host address
// to region and window offset
// ******************************
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module soc_addr_decoder (
  input  soc_bus_pkg::addr_t   addr_i,
  output soc_bus_pkg::region_e region_o,
  output soc_bus_pkg::offset_t offset_o
);
  import soc_bus_pkg::*;

  addr_t win_ofs;

  always_comb begin
    region_o = REGION_NONE;
    win_ofs  = '0;
    if (addr_i >= `MEM_BASE && addr_i < `MEM_BASE + (`MEM_WORDS * 4)) begin
      region_o = REGION_MEM;
      win_ofs  = addr_i - `MEM_BASE;
    end else if (addr_i >= `UART_BASE && addr_i < `UART_BASE + `UART_SIZE) begin
      region_o = REGION_UART;
      win_ofs  = addr_i - `UART_BASE;
    end else if (addr_i >= `CTRL_BASE && addr_i < `CTRL_BASE + `CTRL_SIZE) begin
      region_o = REGION_CTRL;
      win_ofs  = addr_i - `CTRL_BASE;
    end
  end

  // All windows are at most 4 KiB long
  assign offset_o = win_ofs[$bits(offset_t)-1:0];

endmodule

//--- soc_bus_fsm.sv
// ******************************
// Host APB slave FSM
// Steers local accesses and the
// outgoing UART APB transfer
// ******************************
`timescale 1ns/1ps

module soc_bus_fsm (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  soc_bus_pkg::addr_t   paddr_i,
  input  soc_bus_pkg::data_t   pwdata_i,
  output soc_bus_pkg::data_t   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  input  soc_bus_pkg::region_e region_i,
  input  soc_bus_pkg::offset_t offset_i,
  output logic                 uart_psel_o,
  output logic                 uart_penable_o,
  output logic                 uart_pwrite_o,
  output soc_bus_pkg::addr_t   uart_paddr_o,
  output soc_bus_pkg::data_t   uart_pwdata_o,
  input  soc_bus_pkg::data_t   uart_prdata_i,
  input  logic                 uart_pready_i,
  input  logic                 uart_pslverr_i,
  output logic                 timer_en_o,
  input  logic                 timer_expired_i,
  local_bus_if.master          mem_bus,
  local_bus_if.master          ctrl_bus
);
  import soc_bus_pkg::*;

  bus_state_e state_q;
  bus_state_e state_d;
  data_t      resp_rdata_q;
  logic       resp_err_q;
  logic       aligned;
  logic       to_uart;
  data_t      local_rdata;
  logic       local_err;

  // Unaligned accesses are rejected like unmapped ones
  assign aligned = (paddr_i[1:0] == 2'b00);
  assign to_uart = aligned && (region_i == REGION_UART);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Local targets answer in the first access cycle
        if (psel_i && !penable_i && !to_uart) begin
          state_d = ST_LOCAL;
        end else if (psel_i && penable_i && to_uart) begin
          state_d = ST_UART_SETUP;
        end
      end
      ST_LOCAL:       state_d = ST_IDLE;
      ST_UART_SETUP:  state_d = ST_UART_ACCESS;
      ST_UART_ACCESS: begin
        if (uart_pready_i || timer_expired_i) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP:        state_d = ST_IDLE;
      default:        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // UART result, a timeout returns zero data with an error
  always_ff @(posedge clk_i) begin
    if (state_q == ST_UART_ACCESS) begin
      if (uart_pready_i) begin
        resp_rdata_q <= uart_prdata_i;
        resp_err_q   <= uart_pslverr_i;
      end else begin
        resp_rdata_q <= '0;
        resp_err_q   <= 1'b1;
      end
    end
  end

  assign mem_bus.en     = (state_q == ST_LOCAL) && aligned && (region_i == REGION_MEM);
  assign mem_bus.write  = pwrite_i;
  assign mem_bus.offset = offset_i;
  assign mem_bus.wdata  = pwdata_i;

  assign ctrl_bus.en     = (state_q == ST_LOCAL) && aligned && (region_i == REGION_CTRL);
  assign ctrl_bus.write  = pwrite_i;
  assign ctrl_bus.offset = offset_i;
  assign ctrl_bus.wdata  = pwdata_i;

  always_comb begin
    local_rdata = '0;
    local_err   = 1'b1;
    if (aligned) begin
      case (region_i)
        REGION_MEM: begin
          local_rdata = mem_bus.rdata;
          local_err   = mem_bus.err;
        end
        REGION_CTRL: begin
          local_rdata = ctrl_bus.rdata;
          local_err   = ctrl_bus.err;
        end
        default: begin
          local_rdata = '0;
          local_err   = 1'b1;
        end
      endcase
    end
  end

  assign pready_o  = (state_q == ST_LOCAL) || (state_q == ST_RESP);
  assign prdata_o  = (state_q == ST_RESP)  ? resp_rdata_q :
                     (state_q == ST_LOCAL) ? local_rdata  : '0;
  assign pslverr_o = (state_q == ST_RESP)  ? resp_err_q   :
                     (state_q == ST_LOCAL) ? local_err    : 1'b0;

  // Outgoing APB master, address is the offset within the UART window
  assign uart_psel_o    = (state_q == ST_UART_SETUP) || (state_q == ST_UART_ACCESS);
  assign uart_penable_o = (state_q == ST_UART_ACCESS);
  assign uart_pwrite_o  = pwrite_i;
  assign uart_paddr_o   = {{($bits(addr_t) - $bits(offset_t)){1'b0}}, offset_i};
  assign uart_pwdata_o  = pwdata_i;

  assign timer_en_o = (state_q == ST_UART_ACCESS);

endmodule

//--- uart_wait_timer.sv
// ******************************
// UART wait timer
// Saturating wait count and expiry
// ******************************
`timescale 1ns/1ps

module uart_wait_timer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  en_i,
  input  soc_bus_pkg::timeout_t limit_i,
  output logic                  expired_o
);
  import soc_bus_pkg::*;

  timeout_t count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (!en_i) begin
      count_q <= '0;
    end else if (count_q != '1) begin
      count_q <= count_q + 1'b1;
    end
  end

  // A zero limit never expires
  assign expired_o = (limit_i != '0) && (count_q >= limit_i);

endmodule

//--- scratch_mem.sv
// ******************************
// Scratch memory of 64 words
// on the local bus
// ******************************
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module scratch_mem (
  input logic         clk_i,
  local_bus_if.target bus
);
  import soc_bus_pkg::*;

  data_t    mem_q [`MEM_WORDS];
  mem_idx_t word_idx;

  // Byte offset to word index
  assign word_idx = bus.offset[MEM_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (bus.en && bus.write) begin
      mem_q[word_idx] <= bus.wdata;
    end
  end

  assign bus.rdata = mem_q[word_idx];

  // The decoder only passes offsets inside the window
  assign bus.err = 1'b0;

endmodule

//--- ctrl_regs.sv
// ******************************
// Control registers
// Exit value and UART timeout limit
// ******************************
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  local_bus_if.target           bus,
  output soc_bus_pkg::data_t    exit_o,
  output soc_bus_pkg::timeout_t timeout_limit_o
);
  import soc_bus_pkg::*;

  data_t    exit_q;
  timeout_t limit_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q  <= '0;
      limit_q <= `UART_TIMEOUT_RST;
    end else if (bus.en && bus.write) begin
      case (bus.offset)
        `CTRL_EXIT_OFS:    exit_q  <= bus.wdata;
        `CTRL_TIMEOUT_OFS: limit_q <= bus.wdata[$bits(timeout_t)-1:0];
        default:           ;
      endcase
    end
  end

  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.offset)
      `CTRL_EXIT_OFS:    bus.rdata = exit_q;
      `CTRL_TIMEOUT_OFS: bus.rdata = {{($bits(data_t) - $bits(timeout_t)){1'b0}}, limit_q};
      default:           bus.err   = 1'b1;
    endcase
  end

  assign exit_o          = exit_q;
  assign timeout_limit_o = limit_q;

endmodule

//--- soc_bus_top.sv
// ******************************
// Peripheral bus top level
// Decoder, bus FSM, UART timer,
// scratch memory, control regs
// ******************************
`timescale 1ns/1ps

module soc_bus_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Host APB slave
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  soc_bus_pkg::addr_t paddr_i,
  input  soc_bus_pkg::data_t pwdata_i,
  output soc_bus_pkg::data_t prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  // UART APB master
  output logic               uart_psel_o,
  output logic               uart_penable_o,
  output logic               uart_pwrite_o,
  output soc_bus_pkg::addr_t uart_paddr_o,
  output soc_bus_pkg::data_t uart_pwdata_o,
  input  soc_bus_pkg::data_t uart_prdata_i,
  input  logic               uart_pready_i,
  input  logic               uart_pslverr_i,
  output soc_bus_pkg::data_t exit_o
);
  import soc_bus_pkg::*;

  region_e  region;
  offset_t  offset;
  logic     timer_en;
  logic     timer_expired;
  timeout_t timeout_limit;

  local_bus_if mem_bus ();
  local_bus_if ctrl_bus ();

  soc_addr_decoder i_soc_addr_decoder (
    .addr_i  (paddr_i),
    .region_o(region ),
    .offset_o(offset )
  );

  soc_bus_fsm i_soc_bus_fsm (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .psel_i         (psel_i        ),
    .penable_i      (penable_i     ),
    .pwrite_i       (pwrite_i      ),
    .paddr_i        (paddr_i       ),
    .pwdata_i       (pwdata_i      ),
    .prdata_o       (prdata_o      ),
    .pready_o       (pready_o      ),
    .pslverr_o      (pslverr_o     ),
    .region_i       (region        ),
    .offset_i       (offset        ),
    .uart_psel_o    (uart_psel_o   ),
    .uart_penable_o (uart_penable_o),
    .uart_pwrite_o  (uart_pwrite_o ),
    .uart_paddr_o   (uart_paddr_o  ),
    .uart_pwdata_o  (uart_pwdata_o ),
    .uart_prdata_i  (uart_prdata_i ),
    .uart_pready_i  (uart_pready_i ),
    .uart_pslverr_i (uart_pslverr_i),
    .timer_en_o     (timer_en      ),
    .timer_expired_i(timer_expired ),
    .mem_bus        (mem_bus       ),
    .ctrl_bus       (ctrl_bus      )
  );

  uart_wait_timer i_uart_wait_timer (
    .clk_i    (clk_i        ),
    .rst_n_i  (rst_n_i      ),
    .en_i     (timer_en     ),
    .limit_i  (timeout_limit),
    .expired_o(timer_expired)
  );

  scratch_mem i_scratch_mem (
    .clk_i(clk_i  ),
    .bus  (mem_bus)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .bus            (ctrl_bus     ),
    .exit_o         (exit_o       ),
    .timeout_limit_o(timeout_limit)
  );

endmodule

//--- soc_bus_sva.sv
// ******************************
// Protocol assertions on the host
// and UART APB ports
// ******************************
`timescale 1ns/1ps

module soc_bus_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic uart_psel_i,
  input logic uart_penable_i
);

  int unsigned fail_count = 0;

  uart_enable_has_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_penable_i |-> uart_psel_i)
    else begin
      $error("UART penable without psel");
      fail_count++;
    end

  // Setup phase always moves on to the access phase
  uart_setup_to_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (uart_psel_i && !uart_penable_i) |=> (uart_psel_i && uart_penable_i))
    else begin
      $error("UART setup cycle not followed by access cycle");
      fail_count++;
    end

  host_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pready_i |-> (psel_i && penable_i))
    else begin
      $error("pready outside a host access cycle");
      fail_count++;
    end

endmodule

//--- tb_soc_bus.sv
// ******************************
// Testbench of the peripheral bus
// Host APB driver, UART slave model,
// checker, watchdog and verdict
// ******************************
`timescale 1ns/1ps
`include "soc_bus_consts.svh"

module tb_soc_bus;

  localparam int CLK_PERIOD = 8;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [31:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        uart_psel;
  logic        uart_penable;
  logic        uart_pwrite;
  logic [31:0] uart_paddr;
  logic [31:0] uart_pwdata;
  logic [31:0] uart_prdata = '0;
  logic        uart_pready = 1'b0;
  logic        uart_pslverr = 1'b0;
  logic [31:0] exit_val;

  // UART model setup for the current entry, and what it saw
  int          model_waits = 0;
  logic [31:0] model_rdata = '0;
  logic        model_err = 1'b0;
  int          wait_cnt = 0;
  logic        uart_seen = 1'b0;
  logic        uart_answered = 1'b0;
  logic [31:0] seen_paddr = '0;
  logic [31:0] seen_pwdata = '0;
  logic        seen_pwrite = 1'b0;

  int          errors = 0;
  int          checks = 0;
  int          budget_ns = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  soc_bus_top i_soc_bus_top (
    .clk_i         (clk         ),
    .rst_n_i       (rst_n       ),
    .psel_i        (psel        ),
    .penable_i     (penable     ),
    .pwrite_i      (pwrite      ),
    .paddr_i       (paddr       ),
    .pwdata_i      (pwdata      ),
    .prdata_o      (prdata      ),
    .pready_o      (pready      ),
    .pslverr_o     (pslverr     ),
    .uart_psel_o   (uart_psel   ),
    .uart_penable_o(uart_penable),
    .uart_pwrite_o (uart_pwrite ),
    .uart_paddr_o  (uart_paddr  ),
    .uart_pwdata_o (uart_pwdata ),
    .uart_prdata_i (uart_prdata ),
    .uart_pready_i (uart_pready ),
    .uart_pslverr_i(uart_pslverr),
    .exit_o        (exit_val    )
  );

  bind soc_bus_top soc_bus_sva i_soc_bus_sva (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .psel_i        (psel_i        ),
    .penable_i     (penable_i     ),
    .pready_i      (pready_o      ),
    .uart_psel_i   (uart_psel_o   ),
    .uart_penable_i(uart_penable_o)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // One host APB transfer, stalls counts access cycles before pready
  task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int stalls);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    stalls  = 0;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
      stalls++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // UART slave, answers after the wait count of the current entry
  always begin
    @(posedge clk);
    #1;
    if (uart_psel) begin
      uart_seen = 1'b1;
    end
    if (uart_psel && uart_penable) begin
      seen_paddr  = uart_paddr;
      seen_pwdata = uart_pwdata;
      seen_pwrite = uart_pwrite;
      if (wait_cnt >= model_waits) begin
        uart_pready   = 1'b1;
        uart_prdata   = model_rdata;
        uart_pslverr  = model_err;
        uart_answered = 1'b1;
      end else begin
        wait_cnt++;
      end
    end else begin
      uart_pready  = 1'b0;
      uart_prdata  = '0;
      uart_pslverr = 1'b0;
      wait_cnt     = 0;
    end
  end

  initial begin
    wait (budget_ns > 0);
    #(budget_ns);
    $display("watchdog expired, the run did not end within %0d ns", budget_ns);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int          fd;
    int          n;
    int          i;
    int          sum_waits;
    int          wt;
    int          stalls;
    int          tmo_limit;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] e;
    logic [31:0] rdata;
    logic        err;
    logic        is_wr;
    logic        is_uart;
    logic        expect_tmo;
    logic [7:0]  q_op[$];
    logic [31:0] q_addr[$];
    logic [31:0] q_wdata[$];
    logic [31:0] q_rdata[$];
    logic [31:0] q_err[$];
    int          q_wait[$];

    sum_waits = 0;
    tmo_limit = `UART_TIMEOUT_RST;
    fd = $fopen("soc_bus_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open soc_bus_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %d %d", op, a, w, r, e, wt);
          if (n == 6) begin
            q_op.push_back(op);
            q_addr.push_back(a);
            q_wdata.push_back(w);
            q_rdata.push_back(r);
            q_err.push_back(e);
            q_wait.push_back(wt);
            sum_waits += wt;
          end else begin
            $display("malformed line in soc_bus_testdata.txt: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    budget_ns = (sum_waits + 10 * (q_addr.size() + 1)) * CLK_PERIOD;

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("exit_o after reset", exit_val, '0);
    check_value("pready after reset", {31'b0, pready}, '0);
    check_value("uart_psel after reset", {31'b0, uart_psel}, '0);

    for (i = 0; i < q_addr.size(); i++) begin
      is_wr         = (q_op[i] == "W");
      is_uart       = ((q_addr[i] & ~(`UART_SIZE - 1)) == `UART_BASE);
      expect_tmo    = is_uart && (tmo_limit != 0) && (q_wait[i] > tmo_limit);
      model_waits   = q_wait[i];
      model_rdata   = q_rdata[i];
      model_err     = q_err[i][0];
      uart_seen     = 1'b0;
      uart_answered = 1'b0;
      apb_transfer(is_wr, q_addr[i], q_wdata[i], rdata, err, stalls);
      check_value($sformatf("entry %0d pslverr", i), {31'b0, err}, q_err[i]);
      if (!is_wr) begin
        check_value($sformatf("entry %0d prdata", i), rdata, q_rdata[i]);
      end
      if (is_uart) begin
        check_value($sformatf("entry %0d uart_psel seen", i), {31'b0, uart_seen}, 32'd1);
        check_value($sformatf("entry %0d uart_paddr", i), seen_paddr, q_addr[i] - `UART_BASE);
        check_value($sformatf("entry %0d uart_pwrite", i), {31'b0, seen_pwrite}, {31'b0, is_wr});
        if (is_wr) begin
          check_value($sformatf("entry %0d uart_pwdata", i), seen_pwdata, q_wdata[i]);
        end
        // A timed out transfer ends before the UART answers
        check_value($sformatf("entry %0d uart answered", i), {31'b0, uart_answered},
                    {31'b0, !expect_tmo});
        // First access cycle, UART setup, then the waits and the ready access cycle
        if (!expect_tmo) begin
          check_value($sformatf("entry %0d wait states", i), 32'(stalls), 32'(q_wait[i] + 3));
        end
      end else begin
        check_value($sformatf("entry %0d uart_psel seen", i), {31'b0, uart_seen}, '0);
        // Local and unmapped accesses finish in the first access cycle
        check_value($sformatf("entry %0d wait states", i), 32'(stalls), '0);
      end
      if (is_wr && q_err[i] == 0 && q_addr[i] == `CTRL_BASE + `CTRL_EXIT_OFS) begin
        check_value($sformatf("entry %0d exit_o", i), exit_val, q_wdata[i]);
      end
      if (is_wr && q_err[i] == 0 && q_addr[i] == `CTRL_BASE + `CTRL_TIMEOUT_OFS) begin
        tmo_limit = q_wdata[i][7:0];
      end
    end

    $display("tb_soc_bus: %0d entries, %0d checks, %0d errors, %0d assertion failures",
             q_addr.size(), checks, errors, i_soc_bus_top.i_soc_bus_sva.fail_count);
    if (errors == 0 && i_soc_bus_top.i_soc_bus_sva.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- soc_bus_testdata.txt
# op addr wdata rdata err waits (hex, hex, hex, hex, dec, dec)
# rdata is the expected host read data, for UART reads also the data the UART model returns
W 80000000 11223344 00000000 0 0
W 80000004 a5a5a5a5 00000000 0 0
W 800000fc deadbeef 00000000 0 0
W 80000080 01234567 00000000 0 0
R 80000000 00000000 11223344 0 0
R 80000004 00000000 a5a5a5a5 0 0
R 800000fc 00000000 deadbeef 0 0
R 80000080 00000000 01234567 0 0
R d0000004 00000000 00000010 0 0
W d0000000 0000002a 00000000 0 0
R d0000000 00000000 0000002a 0 0
W d0000008 12345678 00000000 1 0
R d0000008 00000000 00000000 1 0
W c0000000 00000041 00000000 0 0
W c0000004 00000042 00000000 0 3
R c0000008 00000000 cafe0001 0 1
R c0000010 00000000 cafe0002 0 5
W c0000ffc 0badf00d 00000000 0 2
R c0000014 00000000 cafe0003 0 4
W c0000020 00000099 00000000 1 1
W d0000004 00000004 00000000 0 0
R d0000004 00000000 00000004 0 0
R c0000018 00000000 00000000 1 10
R c000001c 00000000 cafe0004 0 2
W 10000000 55555555 00000000 1 0
R 10000000 00000000 00000000 1 0
R 80000100 00000000 00000000 1 0

//--- compile.f
+incdir+.
soc_bus_pkg.sv
local_bus_if.sv
soc_addr_decoder.sv
soc_bus_fsm.sv
uart_wait_timer.sv
scratch_mem.sv
ctrl_regs.sv
soc_bus_top.sv
soc_bus_sva.sv
tb_soc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_soc_bus -o sim_soc_bus
./obj_dir/sim_soc_bus +verilator+error+limit+100 | tee sim.log

if grep -qF '** PASS **' sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
